// File: rtl/cp0Pkg.sv
package cp0Pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [4:0]  excCode_t;
    typedef logic [5:0]  hwInt_t;

    // cp0 register numbers
    localparam regAddr_t regBadVAddr = 5'd8;
    localparam regAddr_t regCount    = 5'd9;
    localparam regAddr_t regCompare  = 5'd11;
    localparam regAddr_t regStatus   = 5'd12;
    localparam regAddr_t regCause    = 5'd13;
    localparam regAddr_t regEpc      = 5'd14;

    // cause excCode values
    localparam excCode_t excInt  = 5'd0;
    localparam excCode_t excAdEL = 5'd4;   // fetch or load address error
    localparam excCode_t excAdES = 5'd5;   // store address error
    localparam excCode_t excSys  = 5'd8;
    localparam excCode_t excBp   = 5'd9;
    localparam excCode_t excRi   = 5'd10;
    localparam excCode_t excOv   = 5'd12;

    localparam word_t statusReset  = 32'h0040_0000;  // bev only
    localparam word_t statusWrMask = 32'h0000_ff03;  // im, exl, ie
    localparam word_t causeWrMask  = 32'h0000_0300;  // software ip

    typedef struct packed {
        logic interrupt;
        logic fetchAddrErr;
        logic reservedInstr;
        logic syscall;
        logic breakpoint;
        logic eret;
        logic overflow;
        logic storeAddrErr;
        logic loadAddrErr;
    } exceptFlags_t;

    typedef struct packed {
        logic         mtc0;
        regAddr_t     dst;
        word_t        result;
        word_t        pc;
        word_t        aluOut;
        logic         inDelaySlot;
        exceptFlags_t except;
    } wbBus_t;

    typedef struct packed {
        logic  count;
        logic  compare;
        logic  status;
        logic  cause;
        logic  epc;
        word_t data;
    } cp0WrSel_t;

    typedef struct packed {
        logic     take;
        logic     eret;
        excCode_t code;
        logic     setBadVAddr;
        word_t    badVAddr;
        word_t    pc;
        logic     inDelaySlot;
    } cp0Event_t;

    typedef struct packed {
        word_t status;
        word_t cause;
        word_t epc;
    } cp0View_t;

endpackage

// File: rtl/cp0WbDecode.sv
module cp0WbDecode (
    input  cp0Pkg::wbBus_t    wb,
    output cp0Pkg::cp0WrSel_t wrSel,
    output cp0Pkg::cp0Event_t excEvent
);

    //**************************************************************************
    // mtc0 write strobes
    //**************************************************************************
    assign wrSel.count   = wb.mtc0 && (wb.dst == cp0Pkg::regCount);
    assign wrSel.compare = wb.mtc0 && (wb.dst == cp0Pkg::regCompare);
    assign wrSel.status  = wb.mtc0 && (wb.dst == cp0Pkg::regStatus);
    assign wrSel.cause   = wb.mtc0 && (wb.dst == cp0Pkg::regCause);
    assign wrSel.epc     = wb.mtc0 && (wb.dst == cp0Pkg::regEpc);
    assign wrSel.data    = wb.result;

    //**************************************************************************
    // exception priority, first set flag wins
    //**************************************************************************
    always_comb begin
        excEvent = '0;
        if (wb.except.interrupt) begin
            excEvent.take = 1'b1;
            excEvent.code = cp0Pkg::excInt;
        end else if (wb.except.fetchAddrErr) begin
            excEvent.take        = 1'b1;
            excEvent.code        = cp0Pkg::excAdEL;
            excEvent.setBadVAddr = 1'b1;
            excEvent.badVAddr    = wb.pc;     // bad fetch address is the pc
        end else if (wb.except.reservedInstr) begin
            excEvent.take = 1'b1;
            excEvent.code = cp0Pkg::excRi;
        end else if (wb.except.syscall) begin
            excEvent.take = 1'b1;
            excEvent.code = cp0Pkg::excSys;
        end else if (wb.except.breakpoint) begin
            excEvent.take = 1'b1;
            excEvent.code = cp0Pkg::excBp;
        end else if (wb.except.eret) begin
            excEvent.eret = 1'b1;             // return, not an exception
        end else if (wb.except.overflow) begin
            excEvent.take = 1'b1;
            excEvent.code = cp0Pkg::excOv;
        end else if (wb.except.storeAddrErr) begin
            excEvent.take        = 1'b1;
            excEvent.code        = cp0Pkg::excAdES;
            excEvent.setBadVAddr = 1'b1;
            excEvent.badVAddr    = wb.aluOut;
        end else if (wb.except.loadAddrErr) begin
            excEvent.take        = 1'b1;
            excEvent.code        = cp0Pkg::excAdEL;
            excEvent.setBadVAddr = 1'b1;
            excEvent.badVAddr    = wb.aluOut;
        end

        // epc source only travels with a real exception
        if (excEvent.take) begin
            excEvent.pc          = wb.pc;
            excEvent.inDelaySlot = wb.inDelaySlot;
        end
    end

endmodule

// File: rtl/cp0Timer.sv
module cp0Timer #(
    parameter int countDivider = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::cp0WrSel_t wrSel,
    output cp0Pkg::word_t     count,
    output cp0Pkg::word_t     compare,
    output logic              timerInt
);

    localparam int preW = (countDivider > 1) ? $clog2(countDivider) : 1;
    localparam logic [preW-1:0] preMax = preW'(countDivider - 1);

    logic [preW-1:0] pre;   // clocks since last count step

    // prescaler and count
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pre   <= '0;
            count <= '0;
        end else if (wrSel.count) begin
            pre   <= '0;                  // restart the prescaler on load
            count <= wrSel.data;
        end else if (pre == preMax) begin
            pre   <= '0;
            count <= count + 32'd1;
        end else begin
            pre   <= pre + 1'b1;
        end
    end

    // compare and the timer flag
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            compare  <= '0;
            timerInt <= 1'b0;
        end else if (wrSel.compare) begin
            compare  <= wrSel.data;
            timerInt <= 1'b0;             // writing compare acks the interrupt
        end else if (compare != '0 && count == compare) begin
            timerInt <= 1'b1;
        end
    end

endmodule

// File: rtl/cp0StateRegs.sv
module cp0StateRegs (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::cp0WrSel_t wrSel,
    input  cp0Pkg::cp0Event_t excEvent,
    input  cp0Pkg::hwInt_t    hwInt,
    input  logic              timerInt,
    output cp0Pkg::word_t     status,
    output cp0Pkg::word_t     cause,
    output cp0Pkg::word_t     epc,
    output cp0Pkg::word_t     badVAddr
);

    cp0Pkg::word_t causeQ;
    logic          exl;

    assign exl = status[1];

    // ti shows as soon as the timer flag rises, the stored bit keeps it
    assign cause = {causeQ[31], causeQ[30] | timerInt, causeQ[29:0]};

    //**************************************************************************
    // status and cause
    //**************************************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            status <= cp0Pkg::statusReset;
            causeQ <= '0;
        end else begin
            if (wrSel.status) begin
                status <= (status & ~cp0Pkg::statusWrMask)
                        | (wrSel.data & cp0Pkg::statusWrMask);
            end
            if (wrSel.cause) begin
                causeQ <= (causeQ & ~cp0Pkg::causeWrMask)
                        | (wrSel.data & cp0Pkg::causeWrMask);
            end

            causeQ[15:10] <= hwInt | {5'b0, timerInt};  // ip2 shares the timer
            causeQ[30]    <= causeQ[30] | timerInt;     // sticky ti

            // exception entry wins over a same-cycle mtc0
            if (excEvent.take) begin
                status[1]   <= 1'b1;
                causeQ[6:2] <= excEvent.code;
                if (!exl) begin
                    causeQ[31] <= excEvent.inDelaySlot;   // bd
                end
            end else if (excEvent.eret) begin
                status[1] <= 1'b0;
            end
        end
    end

    //**************************************************************************
    // epc and badvaddr
    //**************************************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            epc      <= '0;
            badVAddr <= '0;
        end else begin
            if (wrSel.epc) begin
                epc <= wrSel.data;
            end
            // nested exception keeps the first epc
            if (excEvent.take && !exl) begin
                epc <= excEvent.inDelaySlot ? excEvent.pc - 32'd4 : excEvent.pc;
            end
            if (excEvent.take && excEvent.setBadVAddr) begin
                badVAddr <= excEvent.badVAddr;
            end
        end
    end

endmodule

// File: rtl/cp0ReadPort.sv
module cp0ReadPort (
    input  cp0Pkg::cp0WrSel_t wrSel,
    input  cp0Pkg::word_t     count,
    input  cp0Pkg::word_t     compare,
    input  cp0Pkg::word_t     status,
    input  cp0Pkg::word_t     cause,
    input  cp0Pkg::word_t     epc,
    input  cp0Pkg::word_t     badVAddr,
    input  cp0Pkg::regAddr_t  rdAddr,
    output cp0Pkg::word_t     rdData,
    output cp0Pkg::cp0View_t  view
);

    cp0Pkg::word_t countByp;
    cp0Pkg::word_t compareByp;
    cp0Pkg::word_t statusByp;
    cp0Pkg::word_t causeByp;
    cp0Pkg::word_t epcByp;

    // bypass of the writeback mtc0
    assign countByp   = wrSel.count   ? wrSel.data : count;
    assign compareByp = wrSel.compare ? wrSel.data : compare;
    assign epcByp     = wrSel.epc     ? wrSel.data : epc;

    // read-only fields keep their stored value
    assign statusByp = wrSel.status
                     ? (status & ~cp0Pkg::statusWrMask) | (wrSel.data & cp0Pkg::statusWrMask)
                     : status;
    assign causeByp  = wrSel.cause
                     ? (cause & ~cp0Pkg::causeWrMask) | (wrSel.data & cp0Pkg::causeWrMask)
                     : cause;

    assign view = '{status: statusByp, cause: causeByp, epc: epcByp};

    always_comb begin
        case (rdAddr)
            cp0Pkg::regCount:    rdData = countByp;
            cp0Pkg::regCompare:  rdData = compareByp;
            cp0Pkg::regStatus:   rdData = statusByp;
            cp0Pkg::regCause:    rdData = causeByp;
            cp0Pkg::regEpc:      rdData = epcByp;
            cp0Pkg::regBadVAddr: rdData = badVAddr;    // no mtc0 path
            default:             rdData = '0;
        endcase
    end

endmodule

// File: rtl/cp0Top.sv
module cp0Top #(
    parameter int countDivider = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  cp0Pkg::wbBus_t    wb,
    input  cp0Pkg::hwInt_t    hwInt,
    input  cp0Pkg::regAddr_t  rdAddr,
    output cp0Pkg::word_t     rdData,
    output cp0Pkg::cp0View_t  view
);

    cp0Pkg::cp0WrSel_t wrSel;
    cp0Pkg::cp0Event_t excEvent;
    cp0Pkg::word_t     count;
    cp0Pkg::word_t     compare;
    cp0Pkg::word_t     status;
    cp0Pkg::word_t     cause;
    cp0Pkg::word_t     epc;
    cp0Pkg::word_t     badVAddr;
    logic              timerInt;

    cp0WbDecode uDecode (
        .wb       (wb),
        .wrSel    (wrSel),
        .excEvent (excEvent)
    );

    cp0Timer #(
        .countDivider (countDivider)
    ) uTimer (
        .clk      (clk),
        .rst      (rst),
        .wrSel    (wrSel),
        .count    (count),
        .compare  (compare),
        .timerInt (timerInt)
    );

    cp0StateRegs uState (
        .clk      (clk),
        .rst      (rst),
        .wrSel    (wrSel),
        .excEvent (excEvent),
        .hwInt    (hwInt),
        .timerInt (timerInt),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .badVAddr (badVAddr)
    );

    cp0ReadPort uRead (
        .wrSel    (wrSel),
        .count    (count),
        .compare  (compare),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .badVAddr (badVAddr),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .view     (view)
    );

endmodule

// File: bench/cp0Top_properties.sv
module cp0Top_properties (
    input logic              clk,
    input logic              rst,
    input cp0Pkg::cp0WrSel_t wrSel,
    input cp0Pkg::cp0Event_t excEvent,
    input cp0Pkg::word_t     status,
    input logic              timerInt
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;   // polled by cp0Tb

    // a return alone leaves exl clear
    eretClearsExl: assert property (@(posedge clk) disable iff (!rst)
        excEvent.eret |=> !status[1])
        else begin
            failCount = failCount + 1;
            $error("exl set after an eret-only event");
        end

    compareAcksTimer: assert property (@(posedge clk) disable iff (!rst)
        wrSel.compare |=> !timerInt)
        else begin
            failCount = failCount + 1;
            $error("timerInt high after a compare write");
        end

    takeOrEret: assert property (@(posedge clk) disable iff (!rst)
        !(excEvent.take && excEvent.eret))
        else begin
            failCount = failCount + 1;
            $error("take and eret set together");
        end

endmodule

bind cp0Top cp0Top_properties props (
    .clk      (clk),
    .rst      (rst),
    .wrSel    (wrSel),
    .excEvent (excEvent),
    .status   (status),
    .timerInt (timerInt)
);

// File: bench/cp0Tb.sv
module cp0Tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int countDivider = 2;
    localparam int randCycles   = 400;
    localparam int testCycles   = 5 + 160 + randCycles;   // reset, directed, random

    typedef struct packed {
        cp0Pkg::word_t pre;
        cp0Pkg::word_t count;
        cp0Pkg::word_t compare;
        logic          timerInt;
        cp0Pkg::word_t status;
        cp0Pkg::word_t cause;      // ti kept sticky here
        cp0Pkg::word_t epc;
        cp0Pkg::word_t badVAddr;
    } modelState_t;

    logic             clk;
    logic             rst;
    cp0Pkg::wbBus_t   wb;
    cp0Pkg::hwInt_t   hwInt;
    cp0Pkg::regAddr_t rdAddr;
    cp0Pkg::word_t    rdData;
    cp0Pkg::cp0View_t view;

    int               seed = 32'hf2d14571;
    string            testName = "reset";
    modelState_t      model;
    modelState_t      modelNext;
    cp0Pkg::word_t    expRd;
    cp0Pkg::cp0View_t expView;

    cp0Top #(.countDivider(countDivider)) dut (
        .clk    (clk),
        .rst    (rst),
        .wb     (wb),
        .hwInt  (hwInt),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .view   (view)
    );

    always #2 clk = ~clk;

    //**************************************************************************
    // reference model, one clock per call
    //**************************************************************************
    function automatic void cp0Model(
        input  modelState_t      cur,
        input  cp0Pkg::wbBus_t   w,
        input  cp0Pkg::hwInt_t   hw,
        input  cp0Pkg::regAddr_t addr,
        output modelState_t      nxt,
        output cp0Pkg::word_t    rd,
        output cp0Pkg::cp0View_t vw
    );
        cp0Pkg::word_t    vCount;
        cp0Pkg::word_t    vCompare;
        cp0Pkg::excCode_t code;
        logic             isEret;
        logic             setBad;
        cp0Pkg::word_t    bad;
        vCount    = (w.mtc0 && w.dst == cp0Pkg::regCount) ? w.result : cur.count;
        vCompare  = (w.mtc0 && w.dst == cp0Pkg::regCompare) ? w.result : cur.compare;
        vw.status = cur.status;
        if (w.mtc0 && w.dst == cp0Pkg::regStatus) begin
            vw.status = (cur.status & ~cp0Pkg::statusWrMask)
                      | (w.result & cp0Pkg::statusWrMask);
        end
        vw.cause = cur.cause;
        if (w.mtc0 && w.dst == cp0Pkg::regCause) begin
            vw.cause[9:8] = w.result[9:8];   // software ip only
        end
        vw.epc = (w.mtc0 && w.dst == cp0Pkg::regEpc) ? w.result : cur.epc;
        case (addr)
            cp0Pkg::regCount:    rd = vCount;
            cp0Pkg::regCompare:  rd = vCompare;
            cp0Pkg::regStatus:   rd = vw.status;
            cp0Pkg::regCause:    rd = vw.cause;
            cp0Pkg::regEpc:      rd = vw.epc;
            cp0Pkg::regBadVAddr: rd = cur.badVAddr;
            default:             rd = '0;
        endcase

        code   = '0;
        isEret = 1'b0;
        setBad = 1'b0;
        bad    = w.aluOut;
        casez (w.except)   // interrupt is the top bit
            9'b1????????: code = cp0Pkg::excInt;
            9'b01???????: begin
                code   = cp0Pkg::excAdEL;
                setBad = 1'b1;
                bad    = w.pc;
            end
            9'b001??????: code = cp0Pkg::excRi;
            9'b0001?????: code = cp0Pkg::excSys;
            9'b00001????: code = cp0Pkg::excBp;
            9'b000001???: isEret = 1'b1;
            9'b0000001??: code = cp0Pkg::excOv;
            9'b00000001?: begin
                code   = cp0Pkg::excAdES;
                setBad = 1'b1;
            end
            9'b000000001: begin
                code   = cp0Pkg::excAdEL;
                setBad = 1'b1;
            end
            default: ;
        endcase

        nxt     = cur;
        nxt.pre = cur.pre + 32'd1;
        if (w.mtc0 && w.dst == cp0Pkg::regCount) begin
            nxt.pre   = '0;
            nxt.count = w.result;
        end else if (cur.pre == countDivider - 1) begin
            nxt.pre   = '0;
            nxt.count = cur.count + 32'd1;
        end
        nxt.compare = vCompare;
        if (w.mtc0 && w.dst == cp0Pkg::regCompare) begin
            nxt.timerInt = 1'b0;
        end else if (cur.compare != '0 && cur.count == cur.compare) begin
            nxt.timerInt = 1'b1;
        end

        nxt.status       = vw.status;
        nxt.cause        = vw.cause;
        nxt.epc          = vw.epc;
        nxt.cause[15:10] = hw | {5'b0, cur.timerInt};   // timer shares ip2
        nxt.cause[30]    = vw.cause[30] | nxt.timerInt;
        if (!isEret && w.except != '0) begin
            if (!cur.status[1]) begin
                nxt.epc       = w.inDelaySlot ? w.pc - 32'd4 : w.pc;
                nxt.cause[31] = w.inDelaySlot;
            end
            nxt.status[1]  = 1'b1;
            nxt.cause[6:2] = code;
            if (setBad) begin
                nxt.badVAddr = bad;
            end
        end else if (isEret) begin
            nxt.status[1] = 1'b0;
        end
    endfunction

    task automatic checkWord(input string name, input cp0Pkg::word_t exp,
                             input cp0Pkg::word_t act);
        if (exp !== act) begin
            $display("** Error: %s rdData expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic checkView(input string name, input cp0Pkg::cp0View_t exp,
                             input cp0Pkg::cp0View_t act);
        if (exp !== act) begin
            $display("** Error: %s view expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // compare before every rising edge
    always @(negedge clk) begin
        if (!rst) begin
            model        = '0;
            model.status = cp0Pkg::statusReset;
        end else begin
            cp0Model(model, wb, hwInt, rdAddr, modelNext, expRd, expView);
            checkWord(testName, expRd, rdData);
            checkView(testName, expView, view);
            if (dut.props.failCount != 0) begin
                $display("an assertion in cp0Top failed during %s", testName);
                $display("Testbench failed");
                $fatal(1);
            end else begin
                model = modelNext;
            end
        end
    end

    //**************************************************************************
    // stimulus
    //**************************************************************************
    function automatic cp0Pkg::word_t nextRand();
        return $random(seed);
    endfunction

    task automatic driveCycle(input cp0Pkg::wbBus_t w, input cp0Pkg::hwInt_t h,
                              input cp0Pkg::regAddr_t a);
        @(posedge clk);
        #1;
        wb     = w;
        hwInt  = h;
        rdAddr = a;
    endtask

    task automatic mtc0Write(input cp0Pkg::regAddr_t dst, input cp0Pkg::word_t data);
        cp0Pkg::wbBus_t w;
        w        = '0;
        w.mtc0   = 1'b1;
        w.dst    = dst;
        w.result = data;
        driveCycle(w, '0, dst);    // bypassed
        driveCycle('0, '0, dst);   // stored
    endtask

    task automatic raiseException(input cp0Pkg::exceptFlags_t flags, input logic slot,
                                  input cp0Pkg::regAddr_t a);
        cp0Pkg::wbBus_t w;
        w             = '0;
        w.except      = flags;
        w.inDelaySlot = slot;
        w.pc          = nextRand();
        w.aluOut      = nextRand();
        driveCycle(w, '0, a);
    endtask

    initial begin
        cp0Pkg::wbBus_t w;
        cp0Pkg::word_t  r;
        clk    = 1'b0;
        rst    = 1'b0;
        wb     = '0;
        hwInt  = '0;
        rdAddr = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;

        testName = "mtc0Bypass";
        mtc0Write(cp0Pkg::regCount, 32'h1234_5678);
        mtc0Write(cp0Pkg::regCompare, 32'hffff_0000);
        mtc0Write(cp0Pkg::regStatus, 32'hffff_ffff);
        mtc0Write(cp0Pkg::regCause, 32'hffff_ffff);
        mtc0Write(cp0Pkg::regEpc, 32'hbfc0_0180);
        driveCycle('0, '0, 5'd3);   // unknown register

        testName = "exceptions";
        for (int i = 0; i < 9; i++) begin
            if (i != 3) begin   // bit 3 is eret
                mtc0Write(cp0Pkg::regStatus, 32'h0);
                raiseException(cp0Pkg::exceptFlags_t'(9'd1 << i), i[0], cp0Pkg::regEpc);
                driveCycle('0, '0, cp0Pkg::regCause);
                driveCycle('0, '0, cp0Pkg::regBadVAddr);
            end
        end

        testName = "nestedEret";
        mtc0Write(cp0Pkg::regStatus, 32'h0000_ff01);
        raiseException(9'h020, 1'b1, cp0Pkg::regEpc);   // syscall in a delay slot
        raiseException(9'h004, 1'b0, cp0Pkg::regEpc);   // overflow, exl already set
        driveCycle('0, '0, cp0Pkg::regCause);
        raiseException(9'h008, 1'b0, cp0Pkg::regStatus);
        driveCycle('0, '0, cp0Pkg::regStatus);

        testName = "timer";
        mtc0Write(cp0Pkg::regCompare, 32'd0);
        mtc0Write(cp0Pkg::regCount, 32'd100);
        mtc0Write(cp0Pkg::regCompare, 32'd108);
        repeat (24) driveCycle('0, '0, cp0Pkg::regCount);
        repeat (4) driveCycle('0, '0, cp0Pkg::regCause);
        mtc0Write(cp0Pkg::regCompare, 32'd5000);
        repeat (4) driveCycle('0, '0, cp0Pkg::regCause);

        testName = "random";
        for (int n = 0; n < randCycles; n++) begin
            r             = nextRand();
            w.mtc0        = r[0] & r[1];
            w.dst         = r[7] ? r[4:0] : 5'd8 + {2'b0, r[6:4]};
            w.result      = nextRand();
            w.pc          = nextRand();
            w.aluOut      = nextRand();
            w.inDelaySlot = r[2];
            w.except      = cp0Pkg::exceptFlags_t'(9'(nextRand() & nextRand() & nextRand()));
            driveCycle(w, r[13:8], r[15] ? r[20:16] : 5'd8 + {2'b0, r[23:21]});
        end
        driveCycle('0, '0, '0);
        @(posedge clk);
        #1;   // let the last assertion actions settle

        if (dut.props.failCount == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1);
        end
    end

    initial begin
        #(testCycles * 4 + 100);
        $display("watchdog expired, the run did not finish in %0d ns", testCycles * 4 + 100);
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

// File: compile.f
rtl/cp0Pkg.sv
rtl/cp0WbDecode.sv
rtl/cp0Timer.sv
rtl/cp0StateRegs.sv
rtl/cp0ReadPort.sv
rtl/cp0Top.sv
bench/cp0Top_properties.sv
bench/cp0Tb.sv

// File: run.sh
#!/bin/sh
# build the cp0 testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module cp0Tb \
    -f compile.f -o cp0Sim

status=0
./obj_dir/cp0Sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation clean"
